// File: rtl/rvExecPkg.sv
package rvExecPkg;

    localparam int xlen = 32;                        // data path width

    typedef logic [xlen-1:0] word;                   // data or address
    typedef logic [31:0]     instrWord;              // raw instruction bits
    typedef logic [4:0]      regAddr;                // register index
    typedef logic [6:0]      opcodeField;            // major opcode, instr[6:0]

    // RV32I major opcodes
    localparam opcodeField opLui    = 7'b0110111;    // u-type
    localparam opcodeField opAuipc  = 7'b0010111;    // u-type, pc relative
    localparam opcodeField opJal    = 7'b1101111;    // j-type
    localparam opcodeField opJalr   = 7'b1100111;    // i-type jump
    localparam opcodeField opBranch = 7'b1100011;    // b-type
    localparam opcodeField opLoad   = 7'b0000011;    // i-type load
    localparam opcodeField opStore  = 7'b0100011;    // s-type
    localparam opcodeField opImm    = 7'b0010011;    // alu with immediate
    localparam opcodeField opReg    = 7'b0110011;    // alu register-register

    typedef enum logic [2:0] {
        immI,                                        // 12 bit signed
        immS,                                        // split store offset
        immB,                                        // branch offset, bit 0 zero
        immU,                                        // upper 20 bits
        immJ                                         // jump offset, bit 0 zero
    } immKind;

    typedef enum logic [1:0] {
        aluAdd,                                      // address and jump math
        aluSub,
        aluFunct,                                    // look at funct3/funct7
        aluPassB                                     // lui
    } aluOpKind;

    typedef enum logic [1:0] {
        wbAlu,
        wbLoad,                                      // value comes back from memory
        wbLink,                                      // pc + 4
        wbPcImm                                      // auipc
    } wbKind;

    typedef enum logic [1:0] {
        pcSeq,                                       // pc + 4
        pcJump,                                      // pc + imm
        pcBranch,                                    // pc + imm if taken
        pcReg                                        // jalr target
    } pcKind;

    typedef struct packed {
        instrWord instr;
        word      pc;
        word      rs1Data;                           // already read from regfile
        word      rs2Data;
    } execReq;

    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     aluSrcImm;                         // operand b from imm
        aluOpKind aluOp;
        immKind   immSel;
        wbKind    wbSel;
        pcKind    pcSel;
        logic     illegal;                           // opcode not decoded
    } ctrlWord;

    typedef struct packed {
        word        pc;
        word        nextPc;
        regAddr     rd;
        logic       regWrite;
        word        wbData;
        logic       memRead;
        logic       memWrite;
        word        memAddr;
        word        storeData;
        logic [2:0] memSize;                         // funct3 passed through
        logic       illegal;
    } execResp;

endpackage

// File: rtl/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
    input  rvExecPkg::instrWord instr,
    output rvExecPkg::ctrlWord  ctrl
);

    rvExecPkg::opcodeField opcode;

    assign opcode = instr[6:0];                      // major opcode only

    // one case per control field, unknown opcodes fall to default
    always_comb begin
        // immediate format to immGen
        case (opcode)
            rvExecPkg::opImm,
            rvExecPkg::opLoad,
            rvExecPkg::opJalr:   ctrl.immSel = rvExecPkg::immI;    // i-type
            rvExecPkg::opStore:  ctrl.immSel = rvExecPkg::immS;    // s-type
            rvExecPkg::opBranch: ctrl.immSel = rvExecPkg::immB;    // b-type
            rvExecPkg::opLui,
            rvExecPkg::opAuipc:  ctrl.immSel = rvExecPkg::immU;    // u-type
            rvExecPkg::opJal:    ctrl.immSel = rvExecPkg::immJ;    // j-type
            default:             ctrl.immSel = rvExecPkg::immI;
        endcase

        // alu operation class
        case (opcode)
            rvExecPkg::opLoad,
            rvExecPkg::opStore,
            rvExecPkg::opJal,
            rvExecPkg::opJalr,
            rvExecPkg::opAuipc:  ctrl.aluOp = rvExecPkg::aluAdd;   // address math
            rvExecPkg::opBranch: ctrl.aluOp = rvExecPkg::aluSub;   // compare is separate
            rvExecPkg::opImm,
            rvExecPkg::opReg:    ctrl.aluOp = rvExecPkg::aluFunct;
            rvExecPkg::opLui:    ctrl.aluOp = rvExecPkg::aluPassB;
            default:             ctrl.aluOp = rvExecPkg::aluAdd;
        endcase

        // register write enable
        case (opcode)
            rvExecPkg::opReg,
            rvExecPkg::opImm,
            rvExecPkg::opLoad,
            rvExecPkg::opLui,
            rvExecPkg::opAuipc,
            rvExecPkg::opJal,
            rvExecPkg::opJalr:   ctrl.regWrite = 1'b1;
            default:             ctrl.regWrite = 1'b0;  // store, branch, illegal
        endcase

        // data memory strobes
        case (opcode)
            rvExecPkg::opLoad:   ctrl.memRead = 1'b1;
            default:             ctrl.memRead = 1'b0;
        endcase

        case (opcode)
            rvExecPkg::opStore:  ctrl.memWrite = 1'b1;
            default:             ctrl.memWrite = 1'b0;
        endcase

        // operand b select
        case (opcode)
            rvExecPkg::opStore,
            rvExecPkg::opImm,
            rvExecPkg::opLoad,
            rvExecPkg::opJalr,
            rvExecPkg::opLui:    ctrl.aluSrcImm = 1'b1;
            default:             ctrl.aluSrcImm = 1'b0;
        endcase

        // write-back source
        case (opcode)
            rvExecPkg::opLoad:   ctrl.wbSel = rvExecPkg::wbLoad;
            rvExecPkg::opJal,
            rvExecPkg::opJalr:   ctrl.wbSel = rvExecPkg::wbLink;   // both link pc+4
            rvExecPkg::opAuipc:  ctrl.wbSel = rvExecPkg::wbPcImm;
            default:             ctrl.wbSel = rvExecPkg::wbAlu;
        endcase

        // next pc kind, branch resolved later in resultMerge
        case (opcode)
            rvExecPkg::opJal:    ctrl.pcSel = rvExecPkg::pcJump;
            rvExecPkg::opBranch: ctrl.pcSel = rvExecPkg::pcBranch;
            rvExecPkg::opJalr:   ctrl.pcSel = rvExecPkg::pcReg;
            default:             ctrl.pcSel = rvExecPkg::pcSeq;    // auipc stays sequential
        endcase

        // illegal flag
        case (opcode)
            rvExecPkg::opLui,
            rvExecPkg::opAuipc,
            rvExecPkg::opJal,
            rvExecPkg::opJalr,
            rvExecPkg::opBranch,
            rvExecPkg::opLoad,
            rvExecPkg::opStore,
            rvExecPkg::opImm,
            rvExecPkg::opReg:    ctrl.illegal = 1'b0;
            default:             ctrl.illegal = 1'b1;
        endcase
    end

endmodule

// File: rtl/immGen.sv
`timescale 1ns/1ns

module immGen (
    input  rvExecPkg::instrWord instr,
    input  rvExecPkg::immKind   immSel,
    output rvExecPkg::word      imm
);

    logic signBit;

    assign signBit = instr[31];                      // all formats sign from bit 31

    always_comb begin
        case (immSel)
            rvExecPkg::immI: imm = {{20{signBit}}, instr[31:20]};
            rvExecPkg::immS: imm = {{20{signBit}}, instr[31:25], instr[11:7]};
            rvExecPkg::immB: imm = {{19{signBit}},            // 13 bit offset
                                    signBit,
                                    instr[7],
                                    instr[30:25],
                                    instr[11:8],
                                    1'b0};                    // halfword aligned
            rvExecPkg::immU: imm = {instr[31:12], 12'b0};     // low bits zero
            rvExecPkg::immJ: imm = {{11{signBit}},            // 21 bit offset
                                    signBit,
                                    instr[19:12],
                                    instr[20],
                                    instr[30:21],
                                    1'b0};
            default:         imm = '0;
        endcase
    end

endmodule

// File: rtl/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
    input  rvExecPkg::instrWord instr,
    input  rvExecPkg::word      rs1Data,
    input  rvExecPkg::word      rs2Data,
    input  rvExecPkg::word      imm,
    input  rvExecPkg::aluOpKind aluOp,
    input  logic                aluSrcImm,
    output rvExecPkg::word      result
);

    rvExecPkg::word opB;
    logic [2:0]     funct3;
    logic           funct7b5;
    logic [4:0]     shamt;
    logic           useSub;

    assign opB      = aluSrcImm ? imm : rs2Data;     // imm or register operand
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];                     // sub / sra select
    assign shamt    = opB[4:0];                      // shifts use low 5 bits only
    assign useSub   = funct7b5 && !aluSrcImm;        // no subi in rv32i

    always_comb begin
        case (aluOp)
            rvExecPkg::aluAdd:   result = rs1Data + opB;
            rvExecPkg::aluSub:   result = rs1Data - opB;
            rvExecPkg::aluPassB: result = opB;      // lui
            rvExecPkg::aluFunct: begin
                case (funct3)
                    3'b000: result = useSub ? rs1Data - opB : rs1Data + opB;
                    3'b001: result = rs1Data << shamt;                        // sll
                    3'b010: result = {31'b0, $signed(rs1Data) < $signed(opB)}; // slt
                    3'b011: result = {31'b0, rs1Data < opB};                  // sltu
                    3'b100: result = rs1Data ^ opB;
                    3'b101: begin
                        // srai keeps bit 30 in the imm field, same test for both
                        if (funct7b5) begin
                            result = $signed(rs1Data) >>> shamt;              // sra
                        end else begin
                            result = rs1Data >> shamt;                        // srl
                        end
                    end
                    3'b110: result = rs1Data | opB;
                    3'b111: result = rs1Data & opB;
                    default: result = '0;
                endcase
            end
            default:             result = '0;
        endcase
    end

    // controlUnit decode must always settle on a defined op
    aluOpKnown: assert final (!$isunknown(aluOp))
        else $error("aluOp unknown from controlUnit");

endmodule

// File: rtl/branchCompare.sv
`timescale 1ns/1ns

module branchCompare (
    input  rvExecPkg::instrWord instr,
    input  rvExecPkg::word      rs1Data,
    input  rvExecPkg::word      rs2Data,
    output logic                taken
);

    logic [2:0] funct3;
    logic       isEq;
    logic       ltSigned;
    logic       ltUnsigned;

    assign funct3     = instr[14:12];
    assign isEq       = (rs1Data == rs2Data);
    assign ltSigned   = $signed(rs1Data) < $signed(rs2Data);
    assign ltUnsigned = rs1Data < rs2Data;

    // only looked at when pcSel says branch
    always_comb begin
        case (funct3)
            3'b000:  taken = isEq;                   // beq
            3'b001:  taken = !isEq;                  // bne
            3'b100:  taken = ltSigned;               // blt
            3'b101:  taken = !ltSigned;              // bge
            3'b110:  taken = ltUnsigned;             // bltu
            3'b111:  taken = !ltUnsigned;            // bgeu
            default: taken = 1'b0;                   // 010/011 not branches
        endcase
    end

endmodule

// File: rtl/resultMerge.sv
`timescale 1ns/1ns

module resultMerge (
    input  logic                 clk,
    input  logic                 rstN,
    input  rvExecPkg::execReq    req,
    input  logic                 inValid,
    output logic                 inReady,
    input  rvExecPkg::ctrlWord   ctrl,
    input  rvExecPkg::word       imm,
    input  rvExecPkg::word       aluResult,
    input  logic                 taken,
    output rvExecPkg::execResp   resp,
    output logic                 outValid,
    input  logic                 outReady
);

    rvExecPkg::word     pcPlus4;
    rvExecPkg::word     pcPlusImm;
    rvExecPkg::word     wbData;
    rvExecPkg::word     nextPc;
    rvExecPkg::execResp respNext;
    logic               accept;

    assign pcPlus4   = req.pc + 32'd4;
    assign pcPlusImm = req.pc + imm;                 // jal, branch, auipc

    always_comb begin
        case (ctrl.wbSel)
            rvExecPkg::wbAlu:   wbData = aluResult;
            rvExecPkg::wbLink:  wbData = pcPlus4;    // jal and jalr
            rvExecPkg::wbPcImm: wbData = pcPlusImm;
            default:            wbData = '0;         // load data filled by memory side
        endcase
    end

    always_comb begin
        case (ctrl.pcSel)
            rvExecPkg::pcJump:   nextPc = pcPlusImm;
            rvExecPkg::pcBranch: nextPc = taken ? pcPlusImm : pcPlus4;
            rvExecPkg::pcReg:    nextPc = {aluResult[31:1], 1'b0};  // jalr clears bit 0
            default:             nextPc = pcPlus4;
        endcase
    end

    always_comb begin
        respNext.pc        = req.pc;
        respNext.nextPc    = nextPc;
        respNext.rd        = req.instr[11:7];
        respNext.regWrite  = ctrl.regWrite;
        respNext.wbData    = wbData;
        respNext.memRead   = ctrl.memRead;
        respNext.memWrite  = ctrl.memWrite;
        respNext.memAddr   = aluResult;              // rs1 + offset
        respNext.storeData = req.rs2Data;
        respNext.memSize   = req.instr[14:12];       // byte/half/word, sign
        respNext.illegal   = ctrl.illegal;
    end

    // free when empty or draining this cycle
    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;                     // refill or go empty
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp <= respNext;                        // payload only on transfer
        end
    end

    // held response must not move until taken
    respStable: assert property (@(posedge clk) disable iff (!rstN)
        (outValid && !outReady) |=> (outValid && $stable(resp)))
        else $error("resp changed while stalled");

    // decode never gives a read and a write together
    memExclusive: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !(resp.memRead && resp.memWrite))
        else $error("memRead and memWrite both set");

    resetEmpty: assert property (@(posedge clk) !rstN |=> !outValid)
        else $error("outValid high after reset");

endmodule

// File: rtl/execStage.sv
`timescale 1ns/1ns

module execStage (
    input  logic               clk,
    input  logic               rstN,
    input  rvExecPkg::execReq  req,
    input  logic               inValid,
    output logic               inReady,
    output rvExecPkg::execResp resp,
    output logic               outValid,
    input  logic               outReady
);

    rvExecPkg::ctrlWord ctrl;
    rvExecPkg::word     imm;
    rvExecPkg::word     aluResult;
    logic               taken;

    controlUnit u_controlUnit (
        .instr (req.instr),
        .ctrl  (ctrl)
    );

    immGen u_immGen (
        .instr  (req.instr),
        .immSel (ctrl.immSel),
        .imm    (imm)
    );

    // alu and comparator see the same operands in parallel
    aluUnit u_aluUnit (
        .instr     (req.instr),
        .rs1Data   (req.rs1Data),
        .rs2Data   (req.rs2Data),
        .imm       (imm),
        .aluOp     (ctrl.aluOp),
        .aluSrcImm (ctrl.aluSrcImm),
        .result    (aluResult)
    );

    branchCompare u_branchCompare (
        .instr   (req.instr),
        .rs1Data (req.rs1Data),
        .rs2Data (req.rs2Data),
        .taken   (taken)
    );

    resultMerge u_resultMerge (
        .clk       (clk),
        .rstN      (rstN),
        .req       (req),
        .inValid   (inValid),
        .inReady   (inReady),
        .ctrl      (ctrl),
        .imm       (imm),
        .aluResult (aluResult),
        .taken     (taken),
        .resp      (resp),
        .outValid  (outValid),
        .outReady  (outReady)
    );

endmodule

// File: test/clockGen.sv
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;                          // 20 ns period
        end
    end

    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);                   // four cycles in reset
        #2 rstN = 1'b1;                              // released just after the edge
    end

endmodule

// File: test/execStageTb.sv
`timescale 1ns/1ns

module execStageTb;

    typedef struct packed {
        rvExecPkg::instrWord instr;
        rvExecPkg::word      pc;
        rvExecPkg::word      rs1Data;
        rvExecPkg::word      rs2Data;
        rvExecPkg::word      wbData;                 // skipped for loads
        rvExecPkg::word      nextPc;
        rvExecPkg::word      memAddr;                // only checked for loads and stores
        logic                regWrite;
        logic                memRead;
        logic                memWrite;
        logic                illegal;
    } tableEntry;

    logic               clk;
    logic               rstN;
    rvExecPkg::execReq  req;
    logic               inValid;
    logic               inReady;
    rvExecPkg::execResp resp;
    logic               outValid;
    logic               outReady;

    tableEntry   vectors[$];
    int          errCount  = 0;
    int          doneCount = 0;
    logic [31:0] lfsrState = 32'h3cff;

    clockGen u_clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    execStage u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .inValid  (inValid),
        .inReady  (inReady),
        .resp     (resp),
        .outValid (outValid),
        .outReady (outReady)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic void addEntry(rvExecPkg::instrWord instr, rvExecPkg::word pc,
            rvExecPkg::word rs1, rvExecPkg::word rs2, rvExecPkg::word wb,
            rvExecPkg::word nextPc, rvExecPkg::word addr, logic [3:0] flags);
        tableEntry e;
        e.instr   = instr;
        e.pc      = pc;
        e.rs1Data = rs1;
        e.rs2Data = rs2;
        e.wbData  = wb;
        e.nextPc  = nextPc;
        e.memAddr = addr;
        {e.regWrite, e.memRead, e.memWrite, e.illegal} = flags;
        vectors.push_back(e);
    endfunction

    // args are instr pc rs1 rs2 wbData nextPc memAddr then {regWrite memRead memWrite illegal}
    function automatic void buildTable();
        // register ops write x5 from x6 and x7
        addEntry('h007302b3, 'h1000, 'h800000f0, 'h14, 'h80000104, 'h1004, 0, 4'b1000); // add
        addEntry('h407302b3, 'h1000, 'h800000f0, 'h14, 'h800000dc, 'h1004, 0, 4'b1000); // sub
        addEntry('h007312b3, 'h1000, 'h800000f0, 'h14, 'h0f000000, 'h1004, 0, 4'b1000); // sll
        addEntry('h007322b3, 'h1000, 'h800000f0, 'h14, 'h00000001, 'h1004, 0, 4'b1000); // slt
        addEntry('h007332b3, 'h1000, 'h800000f0, 'h14, 'h00000000, 'h1004, 0, 4'b1000); // sltu
        addEntry('h007342b3, 'h1000, 'h800000f0, 'h14, 'h800000e4, 'h1004, 0, 4'b1000); // xor
        addEntry('h007352b3, 'h1000, 'h800000f0, 'h14, 'h00000800, 'h1004, 0, 4'b1000); // srl
        addEntry('h407352b3, 'h1000, 'h800000f0, 'h14, 'hfffff800, 'h1004, 0, 4'b1000); // sra
        addEntry('h007362b3, 'h1000, 'h800000f0, 'h14, 'h800000f4, 'h1004, 0, 4'b1000); // or
        addEntry('h007372b3, 'h1000, 'h800000f0, 'h14, 'h00000010, 'h1004, 0, 4'b1000); // and
        // immediate ops ignore the junk rs2 value
        addEntry('hffd30293, 'h1100, 'h10, 'hdeadbeef, 'h0000000d, 'h1104, 0, 4'b1000);
        addEntry('hfff32293, 'h1100, 'hfffffffe, 'hdeadbeef, 'h1, 'h1104, 0, 4'b1000); // slti
        addEntry('hfff33293, 'h1100, 'hfffffffe, 'hdeadbeef, 'h1, 'h1104, 0, 4'b1000); // sltiu
        addEntry('h0ff34293, 'h1100, 'h12345678, 'hdeadbeef, 'h12345687, 'h1104, 0, 4'b1000);
        addEntry('h70036293, 'h1100, 'h12345678, 'hdeadbeef, 'h12345778, 'h1104, 0, 4'b1000);
        addEntry('h0f037293, 'h1100, 'h12345678, 'hdeadbeef, 'h00000070, 'h1104, 0, 4'b1000);
        addEntry('h00831293, 'h1100, 'h12345678, 'hdeadbeef, 'h34567800, 'h1104, 0, 4'b1000);
        addEntry('h00835293, 'h1100, 'h87654321, 'hdeadbeef, 'h00876543, 'h1104, 0, 4'b1000);
        addEntry('h40835293, 'h1100, 'h87654321, 'hdeadbeef, 'hff876543, 'h1104, 0, 4'b1000);
        // each branch condition taken then not taken with offsets +16 and -8
        addEntry('h00730863, 'h1000, 'h5, 'h5, 0, 'h1010, 0, 4'b0000);                 // beq
        addEntry('hfe730ce3, 'h1000, 'h5, 'h6, 0, 'h1004, 0, 4'b0000);
        addEntry('hfe731ce3, 'h1000, 'h5, 'h6, 0, 'h0ff8, 0, 4'b0000);                 // bne
        addEntry('h00731863, 'h1000, 'h7, 'h7, 0, 'h1004, 0, 4'b0000);
        addEntry('h00734863, 'h1000, 'hffffffff, 'h1, 0, 'h1010, 0, 4'b0000);          // blt
        addEntry('hfe734ce3, 'h1000, 'h1, 'hffffffff, 0, 'h1004, 0, 4'b0000);
        addEntry('hfe735ce3, 'h1000, 'h1, 'hffffffff, 0, 'h0ff8, 0, 4'b0000);          // bge
        addEntry('h00735863, 'h1000, 'hffffffff, 'h1, 0, 'h1004, 0, 4'b0000);
        addEntry('h00736863, 'h1000, 'h1, 'hffffffff, 0, 'h1010, 0, 4'b0000);          // bltu
        addEntry('hfe736ce3, 'h1000, 'hffffffff, 'h1, 0, 'h1004, 0, 4'b0000);
        addEntry('hfe737ce3, 'h1000, 'hffffffff, 'h1, 0, 'h0ff8, 0, 4'b0000);          // bgeu
        addEntry('h00737863, 'h1000, 'h1, 'hffffffff, 0, 'h1004, 0, 4'b0000);
        // jumps and upper immediates
        addEntry('h100002ef, 'h2000, 'h0, 'h0, 'h2004, 'h2100, 0, 4'b1000);            // jal +256
        addEntry('hffdff2ef, 'h2000, 'h0, 'h0, 'h2004, 'h1ffc, 0, 4'b1000);            // jal -4
        addEntry('h005302e7, 'h2000, 'h3000, 'h0, 'h2004, 'h3004, 0, 4'b1000);         // odd target
        addEntry('habcde2b7, 'h2000, 'h11111111, 'h0, 'habcde000, 'h2004, 0, 4'b1000); // lui
        addEntry('h00010297, 'h2000, 'h0, 'h0, 'h00012000, 'h2004, 0, 4'b1000);        // auipc
        // loads and stores off x6
        addEntry('hffc32283, 'h3000, 'h8000, 'hcafef00d, 0, 'h3004, 'h7ffc, 4'b1100);  // lw -4
        addEntry('h01034283, 'h3000, 'h8000, 'hcafef00d, 0, 'h3004, 'h8010, 4'b1100);  // lbu 16
        addEntry('h00732423, 'h3000, 'h8000, 'hcafef00d, 0, 'h3004, 'h8008, 4'b0010);  // sw 8
        addEntry('hfe730fa3, 'h3000, 'h8000, 'hcafef00d, 0, 'h3004, 'h7fff, 4'b0010);  // sb -1
        // system and custom-0 opcodes are not decoded
        addEntry('h00000073, 'h4000, 'h0, 'h0, 0, 'h4004, 0, 4'b0001);
        addEntry('h0000000b, 'h4000, 'h0, 'h0, 0, 'h4004, 0, 4'b0001);
    endfunction

    task automatic checkWord(int idx, string name, rvExecPkg::word got, rvExecPkg::word exp);
        if (got !== exp) begin
            $display("[ERROR] entry %0d %s got %h expected %h", idx, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkBit(int idx, string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] entry %0d %s got %h expected %h", idx, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkResp(int idx, tableEntry e, rvExecPkg::execResp got);
        int errBefore;
        errBefore = errCount;
        checkWord(idx, "pc", got.pc, e.pc);                         // order check too
        checkWord(idx, "nextPc", got.nextPc, e.nextPc);
        checkWord(idx, "rd", rvExecPkg::word'(got.rd), rvExecPkg::word'(e.instr[11:7]));
        checkBit(idx, "regWrite", got.regWrite, e.regWrite);
        checkBit(idx, "memRead", got.memRead, e.memRead);
        checkBit(idx, "memWrite", got.memWrite, e.memWrite);
        checkBit(idx, "illegal", got.illegal, e.illegal);
        if (e.regWrite && !e.memRead) begin
            checkWord(idx, "wbData", got.wbData, e.wbData);         // load data comes later
        end
        if (e.memRead || e.memWrite) begin
            checkWord(idx, "memAddr", got.memAddr, e.memAddr);
            checkWord(idx, "memSize", rvExecPkg::word'(got.memSize),
                      rvExecPkg::word'(e.instr[14:12]));
        end
        if (e.memWrite) begin
            checkWord(idx, "storeData", got.storeData, e.rs2Data);
        end
        $display("entry %0d instr %h %s", idx, e.instr, (errCount == errBefore) ? "ok" : "bad");
    endtask

    task automatic driveAll();
        bit accepted;
        req     = '0;
        inValid = 1'b0;
        wait (rstN);
        @(posedge clk);
        #2;
        checkBit(-1, "outValid after reset", outValid, 1'b0);
        checkBit(-1, "inReady after reset", inReady, 1'b1);
        foreach (vectors[i]) begin
            req     = {vectors[i].instr, vectors[i].pc, vectors[i].rs1Data, vectors[i].rs2Data};
            inValid = 1'b1;
            do begin
                @(negedge clk);
                accepted = inReady;                  // stable until the next edge
                @(posedge clk);
                #2;
            end while (!accepted);
        end
        inValid = 1'b0;
    endtask

    // ends a hung run after reset plus 20 cycles per entry
    task automatic watchdog();
        #((vectors.size() * 20 + 10) * 20);
        $display("timeout, only %0d of %0d responses seen", doneCount, vectors.size());
        $display("TEST FAILED");
        $finish;
    endtask

    // random back-pressure with one lfsr step per bit
    initial begin
        outReady = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            lfsrState = lfsrStep(lfsrState);
            outReady  = lfsrState[0];
        end
    end

    initial begin
        buildTable();
        fork
            driveAll();
            watchdog();
        join_none
        wait (rstN);
        while (doneCount < vectors.size()) begin
            @(negedge clk);
            if (outValid && outReady) begin           // transfer on the coming edge
                checkResp(doneCount, vectors[doneCount], resp);
                doneCount++;
            end
        end
        repeat (2) @(negedge clk);
        if (outValid) begin
            $display("extra response after the last table entry");
            errCount++;
        end
        $display("%0d entries checked, %0d errors", doneCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/rvExecPkg.sv
rtl/controlUnit.sv
rtl/immGen.sv
rtl/aluUnit.sv
rtl/branchCompare.sv
rtl/resultMerge.sv
rtl/execStage.sv
test/clockGen.sv
test/execStageTb.sv
